// File: vdiv_pkg.sv
// Shared definitions for the vector FP16 divide unit
// Half-precision field types, lane and vector bundles, unit constants

`default_nettype none

package vdiv_pkg;

    // Lanes in one vector issue
    localparam int LANES = 4;

    // Half-precision format
    localparam int FP16_BIAS    = 15;
    localparam int FP16_EXP_MAX = 30;

    // Significand divider shape
    // Dividend is hidden bit and mantissa shifted up by 12, so the early steps are known
    localparam int DIV_SIZE = 23;
    localparam int DIV_SKIP = 11;

    typedef logic [15:0] fp16_t;
    typedef logic [4:0]  fp16_exp_t;
    typedef logic [9:0]  fp16_man_t;

    // Quiet NaN returned for every invalid divide
    localparam fp16_man_t FP16_QNAN_MAN = 10'h200;

    // One lane's operand pair
    typedef struct packed {
        fp16_t dividend;
        fp16_t divisor;
    } div_operands_t;

    // Whole vector issue
    typedef struct packed {
        div_operands_t [LANES-1:0] ops;
    } vdiv_req_t;

    // Whole vector result
    typedef struct packed {
        fp16_t [LANES-1:0] quot;
    } vdiv_resp_t;

endpackage

`default_nettype wire

// File: int_divider.sv
// Iterative restoring unsigned divider
// Preloads the upper dividend bits, then produces one quotient bit per cycle
// and pulses done with the quotient held in a register

`timescale 1ns/1ps
`default_nettype none

module int_divider #(
    parameter int SIZE = 23,
    parameter int SKIP = 11
) (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            start,
    input  logic [SIZE-1:0] dividend,
    input  logic [SIZE-1:0] divisor,
    output logic [SIZE-1:0] quotient,
    output logic            done
);
    localparam int ITERS = SIZE - SKIP;
    localparam int CW    = $clog2(ITERS + 1);

    logic [SIZE-1:0]  rem;
    logic [SIZE-1:0]  dvsr;
    logic [ITERS-1:0] dvnd_lo;
    logic [CW-1:0]    iter;
    logic             running;

    logic [SIZE-1:0] rem_top;
    logic [SIZE-1:0] rem_pre;
    logic [SIZE-1:0] rem_first;
    logic [SIZE-1:0] rem_step;
    logic            q_pre;
    logic            q_first;
    logic            q_step;

    // One shift-subtract step that returns {quotient bit, new remainder}
    function automatic logic [SIZE:0] div_step(
        input logic [SIZE-1:0] r,
        input logic            b,
        input logic [SIZE-1:0] d
    );
        logic [SIZE:0] sh;
        sh = {r, b};
        if (sh >= {1'b0, d})
            return {1'b1, sh[SIZE-1:0] - d};
        else
            return {1'b0, sh[SIZE-1:0]};
    endfunction

    // Quotient bits above ITERS are zero since the divisor sits in the low bits
    // The preload step yields bit ITERS and the first iteration runs in the start cycle
    assign rem_top = dividend >> (ITERS + 1);
    assign {q_pre, rem_pre}     = div_step(rem_top, dividend[ITERS], divisor);
    assign {q_first, rem_first} = div_step(rem_pre, dividend[ITERS-1], divisor);
    assign {q_step, rem_step}   = div_step(rem, dvnd_lo[ITERS-1], dvsr);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            iter    <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                iter    <= CW'(ITERS - 1);
            end else if (running) begin
                iter <= iter - 1'b1;
                if (iter == CW'(1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Datapath registers
    always_ff @(posedge CLK) begin
        if (start) begin
            dvsr     <= divisor;
            rem      <= rem_first;
            dvnd_lo  <= dividend[ITERS-1:0] << 1;
            quotient <= SIZE'({q_pre, q_first});
        end else if (running) begin
            rem      <= rem_step;
            dvnd_lo  <= dvnd_lo << 1;
            quotient <= {quotient[SIZE-2:0], q_step};
        end
    end

endmodule

`default_nettype wire

// File: fp16_div.sv
// FP16 divide lane
// NaN, infinity and zero operands bypass the divider and finish in one cycle;
// other operands divide the significands, normalize, round half up and flush

`timescale 1ns/1ps
`default_nettype none

module fp16_div (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    en,
    input  vdiv_pkg::div_operands_t ops,
    output vdiv_pkg::fp16_t         result,
    output logic                    done
);
    import vdiv_pkg::*;

    // Quotient bit set when the significand ratio is 2 or more
    localparam int QMSB = DIV_SIZE - DIV_SKIP;
    localparam int PAD  = DIV_SIZE - 11;

    logic      a_sign, b_sign;
    fp16_exp_t a_exp, b_exp;
    fp16_man_t a_man, b_man;
    logic      a_zero, b_zero;
    logic      a_inf, b_inf;
    logic      a_nan, b_nan;
    logic      is_nan, is_inf, is_zero;
    logic      special;
    logic      sign;

    logic signed [6:0] exp_raw;

    // Held for the divider path
    logic              sign_q;
    logic signed [6:0] exp_q;

    logic                start;
    logic [DIV_SIZE-1:0] div_dividend;
    logic [DIV_SIZE-1:0] div_divisor;
    logic [DIV_SIZE-1:0] div_quot;
    logic                div_done;

    fp16_man_t         man_norm;
    logic              round_bit;
    logic [10:0]       man_rnd;
    logic signed [6:0] exp_norm;
    logic signed [6:0] exp_fin;
    fp16_t             special_res;
    fp16_t             normal_res;

    assign {a_sign, a_exp, a_man} = ops.dividend;
    assign {b_sign, b_exp, b_man} = ops.divisor;
    assign sign = a_sign ^ b_sign;

    // Subnormals count as zero
    assign a_zero = (a_exp == '0);
    assign b_zero = (b_exp == '0);
    assign a_inf  = (&a_exp) && (a_man == '0);
    assign b_inf  = (&b_exp) && (b_man == '0);
    assign a_nan  = (&a_exp) && (a_man != '0);
    assign b_nan  = (&b_exp) && (b_man != '0);

    assign is_nan  = a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf);
    assign is_inf  = !is_nan && (a_inf || b_zero);
    assign is_zero = !is_nan && !is_inf && (a_zero || b_inf);
    assign special = is_nan || is_inf || is_zero;

    always_comb begin
        if (is_nan)
            special_res = {sign, fp16_exp_t'('1), FP16_QNAN_MAN};
        else if (is_inf)
            special_res = {sign, fp16_exp_t'('1), fp16_man_t'('0)};
        else
            special_res = {sign, fp16_exp_t'('0), fp16_man_t'('0)};
    end

    // Biased exponent of the quotient before normalization
    assign exp_raw = {2'b00, a_exp} - {2'b00, b_exp} + 7'(FP16_BIAS);

    always_ff @(posedge CLK) begin
        if (en) begin
            sign_q <= sign;
            exp_q  <= exp_raw;
        end
    end

    assign start        = en && !special;
    assign div_dividend = {|a_exp, a_man, {PAD{1'b0}}};
    assign div_divisor  = {{PAD{1'b0}}, |b_exp, b_man};

    int_divider #(
        .SIZE (DIV_SIZE),
        .SKIP (DIV_SKIP)
    ) u_divider (
        .CLK      (CLK),
        .nRST     (nRST),
        .start    (start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .quotient (div_quot),
        .done     (div_done)
    );

    // Normalize to one leading bit, then round half up on the next bit
    always_comb begin
        if (div_quot[QMSB]) begin
            {man_norm, round_bit} = div_quot[QMSB-1 -: 11];
            exp_norm = exp_q;
        end else begin
            {man_norm, round_bit} = div_quot[QMSB-2 -: 11];
            exp_norm = exp_q - 7'sd1;
        end
        man_rnd = {1'b0, man_norm} + {10'b0, round_bit};
        // A carry out of the mantissa leaves it zero and bumps the exponent
        exp_fin = exp_norm + {6'b0, man_rnd[10]};

        if (exp_fin > FP16_EXP_MAX)
            normal_res = {sign_q, fp16_exp_t'('1), fp16_man_t'('0)};
        else if (exp_fin < 1)
            normal_res = {sign_q, fp16_exp_t'('0), fp16_man_t'('0)};
        else
            normal_res = {sign_q, exp_fin[4:0], man_rnd[9:0]};
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            done <= 1'b0;
        else
            done <= (en && special) || div_done;
    end

    always_ff @(posedge CLK) begin
        if (en && special)
            result <= special_res;
        else if (div_done)
            result <= normal_res;
    end

endmodule

`default_nettype wire

// File: vdiv_unit.sv
// Four-lane FP16 vector divide unit
// Accepts one vector issue while idle, tracks lane completions
// and reports the whole vector with a one-cycle done strobe

`timescale 1ns/1ps
`default_nettype none

module vdiv_unit (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 issue,
    input  vdiv_pkg::vdiv_req_t  req,
    output logic                 done,
    output vdiv_pkg::vdiv_resp_t resp,
    output logic                 busy
);
    import vdiv_pkg::*;

    logic             accept;
    logic [LANES-1:0] lane_done;
    logic [LANES-1:0] mask;
    logic [LANES-1:0] mask_next;
    logic             all_done;
    fp16_t            lane_result [LANES];

    // Issues during a divide are dropped
    assign accept = issue && !busy;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        fp16_div u_lane (
            .CLK    (CLK),
            .nRST   (nRST),
            .en     (accept),
            .ops    (req.ops[i]),
            .result (lane_result[i]),
            .done   (lane_done[i])
        );
    end

    // Lanes finish at different times and are collected in the mask
    assign mask_next = mask | lane_done;
    assign all_done  = busy && (&mask_next);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            done <= 1'b0;
            mask <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                mask <= '0;
            end else if (busy) begin
                mask <= mask_next;
                if (all_done) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Result vector holds until the next completion
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp <= '0;
        end else if (all_done) begin
            for (int i = 0; i < LANES; i++) begin
                resp.quot[i] <= lane_result[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_vdiv.sv
// Testbench for the four-lane FP16 vector divide unit
// Directed special, rounding and flush vectors, busy gating and random vectors,
// all checked against a reference divide function

`timescale 1ns/1ps
`default_nettype none

module tb_vdiv;
    import vdiv_pkg::*;

    logic       CLK;
    logic       nRST;
    logic       issue;
    vdiv_req_t  req;
    logic       done;
    vdiv_resp_t resp;
    logic       busy;

    vdiv_req_t  r;
    vdiv_req_t  r_ignored;
    vdiv_resp_t expected_resp;
    int         cycles;

    vdiv_unit UUT (
        .CLK  (CLK),
        .nRST (nRST),
        .issue(issue),
        .req  (req),
        .done (done),
        .resp (resp),
        .busy (busy)
    );

    always #10 CLK = ~CLK;

    // Expected quotient from the FP16 rules with subnormals read as zero
    function automatic fp16_t ref_fp16_div(input fp16_t a, input fp16_t b);
        logic s;
        logic az, bz, ai, bi, an, bn;
        int   ea, eb, ma, mb, q, e, m, rb;
        s  = a[15] ^ b[15];
        ea = a[14:10];
        eb = b[14:10];
        ma = a[9:0];
        mb = b[9:0];
        az = (ea == 0);
        bz = (eb == 0);
        ai = (ea == 31) && (ma == 0);
        bi = (eb == 31) && (mb == 0);
        an = (ea == 31) && (ma != 0);
        bn = (eb == 31) && (mb != 0);
        if (an || bn || (az && bz) || (ai && bi))
            return {s, 5'h1f, FP16_QNAN_MAN};
        if (ai || bz)
            return {s, 5'h1f, 10'h000};
        if (az || bi)
            return {s, 15'h0000};
        // Ratio of significands with 12 fraction bits
        q = ((1024 + ma) * 4096) / (1024 + mb);
        e = ea - eb + FP16_BIAS;
        if (q >= 4096) begin
            m  = (q >> 2) % 1024;
            rb = (q >> 1) % 2;
        end else begin
            m  = (q >> 1) % 1024;
            rb = q % 2;
            e  = e - 1;
        end
        m = m + rb;
        if (m == 1024) begin
            m = 0;
            e = e + 1;
        end
        if (e > FP16_EXP_MAX)
            return {s, 5'h1f, 10'h000};
        if (e < 1)
            return {s, 15'h0000};
        return {s, 5'(e), 10'(m)};
    endfunction

    function automatic fp16_t rand_normal();
        logic      s;
        fp16_exp_t e;
        fp16_man_t m;
        s = 1'($urandom % 2);
        e = fp16_exp_t'(1 + $urandom % 30);
        m = fp16_man_t'($urandom);
        return {s, e, m};
    endfunction

    task automatic stop_with_error();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_fp16(input int lane, input fp16_t got, input fp16_t expected);
        if (got !== expected) begin
            $display("Error at %0t: resp.quot[%0d] = %h, expected %h",
                     $time, lane, got, expected);
            stop_with_error();
        end
    endtask

    task automatic check_latency(input int got, input int expected);
        if (got != expected) begin
            $display("Error at %0t: done latency = %0d, expected %0d", $time, got, expected);
            stop_with_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, expected);
            stop_with_error();
        end
    endtask

    // One-cycle issue strobe that ends on the following edge
    task automatic drive_issue(input vdiv_req_t v);
        @(posedge CLK);
        issue <= 1'b1;
        req   <= v;
        @(posedge CLK);
        issue <= 1'b0;
    endtask

    // Counts cycles from the issue cycle until done is seen at a falling edge
    task automatic wait_done(output int n);
        logic seen;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 100) begin
            @(negedge CLK);
            n    = n + 1;
            seen = done;
        end
        if (!seen) begin
            $display("Timeout at %0t: done never came within 100 cycles of the issue", $time);
            stop_with_error();
        end
    endtask

    task automatic run_vector(input vdiv_req_t v, input int expected_latency);
        int lat;
        drive_issue(v);
        wait_done(lat);
        for (int i = 0; i < LANES; i++) begin
            check_fp16(i, resp.quot[i], ref_fp16_div(v.ops[i].dividend, v.ops[i].divisor));
        end
        check_latency(lat, expected_latency);
    endtask

    initial begin
        CLK   = 1'b0;
        nRST  = 1'b0;
        issue = 1'b0;
        req   = '0;
        r     = '0;
        void'($urandom(40));

        repeat (4) @(posedge CLK);
        nRST <= 1'b1;

        // Idle outputs after reset
        repeat (3) begin
            @(negedge CLK);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
            for (int i = 0; i < LANES; i++)
                check_fp16(i, resp.quot[i], 16'h0000);
        end

        // All lanes special with 0/0, -inf/inf, 1/NaN and -1/0
        r.ops[0] = {16'h0000, 16'h0000};
        r.ops[1] = {16'hfc00, 16'h7c00};
        r.ops[2] = {16'h3c00, 16'h7e00};
        r.ops[3] = {16'hbc00, 16'h0000};
        run_vector(r, 2);

        // inf/-2, -0/-3, 1/-inf, -5/-0
        r.ops[0] = {16'h7c00, 16'hc000};
        r.ops[1] = {16'h8000, 16'hc200};
        r.ops[2] = {16'h3c00, 16'hfc00};
        r.ops[3] = {16'hc500, 16'h8000};
        run_vector(r, 2);

        // 1.5/1, 5/4, 5/3 rounds up, 1/-3
        r.ops[0] = {16'h3e00, 16'h3c00};
        r.ops[1] = {16'h4500, 16'h4400};
        r.ops[2] = {16'h4500, 16'h4200};
        r.ops[3] = {16'h3c00, 16'hc200};
        run_vector(r, 14);

        // Overflow, negative overflow, underflow and a subnormal dividend
        r.ops[0] = {16'h7bff, 16'h0400};
        r.ops[1] = {16'hfbff, 16'h0400};
        r.ops[2] = {16'h8400, 16'h7bff};
        r.ops[3] = {16'h0001, 16'h3c00};
        run_vector(r, 14);

        // Second issue lands while busy and must be dropped
        r.ops[0] = {16'h4900, 16'h4000};
        r.ops[1] = {16'h3c00, 16'h3e00};
        r.ops[2] = {16'hc500, 16'h3800};
        r.ops[3] = {16'h4248, 16'h4100};
        r_ignored = '0;
        for (int i = 0; i < LANES; i++)
            expected_resp.quot[i] = ref_fp16_div(r.ops[i].dividend, r.ops[i].divisor);
        drive_issue(r);
        repeat (3) begin
            @(negedge CLK);
            check_bit("busy", busy, 1'b1);
        end
        drive_issue(r_ignored);
        wait_done(cycles);
        // Done comes 14 cycles after the accepted issue and so 10 after the dropped one
        check_latency(cycles, 10);
        for (int i = 0; i < LANES; i++)
            check_fp16(i, resp.quot[i], expected_resp.quot[i]);
        repeat (20) begin
            @(negedge CLK);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
        for (int i = 0; i < LANES; i++)
            check_fp16(i, resp.quot[i], expected_resp.quot[i]);

        // Random normal operands issued as soon as each done is seen
        for (int n = 0; n < 300; n++) begin
            for (int i = 0; i < LANES; i++) begin
                r.ops[i].dividend = rand_normal();
                r.ops[i].divisor  = rand_normal();
            end
            run_vector(r, 14);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
vdiv_pkg.sv
int_divider.sv
fp16_div.sv
vdiv_unit.sv
tb_vdiv.sv

// File: Makefile
# Verilator build and run for the FP16 vector divide unit

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_vdiv
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
